// ==== sources.f ====
rtl/c64_glue_pkg.sv
rtl/phase_enable_gen.sv
rtl/core_ctrl_regs.sv
rtl/osd_framebuffer.sv
rtl/osd_overlay.sv
rtl/c64_glue_top.sv
testbench/tb_c64_glue.sv

// ==== testbench/tb_c64_glue.sv ====
/*
 * c64 glue testbench
 * wishbone register and framebuffer traffic, raster stimulus and a
 * monitor that checks the top level against reference models
 */
module tb_c64_glue;
  timeunit 1ns;
  timeprecision 1ps;
  import c64_glue_pkg::*;

  localparam int line_de   = 264;
  localparam int line_cyc  = line_de + 8;
  localparam int n_lines   = 66 + 10 + 3 + 8;
  localparam int n_xfers   = 800;
  localparam int ack_limit = 64;
  // worst case per transfer, per raster line, plus idle waits, times two
  localparam longint watchdog_ns = 2 * 8 * (n_xfers * 12 + n_lines * line_cyc + 500);

  logic              clk_8mhz = 1'b0;
  logic              rst;
  logic              wb_cyc;
  logic              wb_stb;
  logic              wb_we;
  logic [adr_w-1:0]  wb_adr;
  logic [31:0]       wb_dat;
  logic [3:0]        wb_sel;
  logic [31:0]       wb_rdat;
  logic              wb_ack;
  logic [key_w-1:0]  pad1_key;
  logic [key_w-1:0]  pad2_key;
  logic              drive_motor;
  logic              drive_led;
  logic [track_w-1:0] drive_track;
  logic              vid_hs;
  logic              vid_vs;
  logic              vid_de;
  logic [23:0]       emu_rgb;
  logic [23:0]       vid_rgb;
  logic [1:0]        cart_type;
  logic [kbd_w-1:0]  kbd_mask;
  logic [joy_w-1:0]  joy1;
  logic [joy_w-1:0]  joy2;
  logic              ph1_en;
  logic              ph2_en;
  logic              emu_rst;
  logic [8:0]        ras_x;
  logic [8:0]        ras_y;

  // model state kept by the monitor
  logic [31:0]           fb_model [fb_words];
  logic [osd_ctrl_w-1:0] mdl_osd;
  logic [c64_ctrl_w-1:0] mdl_ctrl;
  logic [kbd_w-1:0]      mdl_kbd;
  int                    ph_cnt;
  logic                  prev_ph2;
  logic                  prev_ack;
  logic                  exp_emu_rst;

  int bus_errs   = 0;
  int reg_errs   = 0;
  int joy_errs   = 0;
  int phase_errs = 0;
  int fb_errs    = 0;
  int pix_errs   = 0;
  int late_acks  = 0;

  logic [31:0] lfsr = 32'hcbb1_117d;

  always #4 clk_8mhz = ~clk_8mhz;

  c64_glue_top dut0 (
    .clk_8mhz     (clk_8mhz),
    .rst          (rst),
    .i_wb_cyc     (wb_cyc),
    .i_wb_stb     (wb_stb),
    .i_wb_we      (wb_we),
    .i_wb_adr     (wb_adr),
    .i_wb_dat     (wb_dat),
    .i_wb_sel     (wb_sel),
    .o_wb_dat     (wb_rdat),
    .o_wb_ack     (wb_ack),
    .i_pad1_key   (pad1_key),
    .i_pad2_key   (pad2_key),
    .i_drive_motor(drive_motor),
    .i_drive_led  (drive_led),
    .i_drive_track(drive_track),
    .i_vid_hs     (vid_hs),
    .i_vid_vs     (vid_vs),
    .i_vid_de     (vid_de),
    .i_emu_rgb    (emu_rgb),
    .o_vid_rgb    (vid_rgb),
    .o_cart_type  (cart_type),
    .o_kbd_mask   (kbd_mask),
    .o_joy1       (joy1),
    .o_joy2       (joy2),
    .o_ph1_en     (ph1_en),
    .o_ph2_en     (ph2_en),
    .o_emu_rst    (emu_rst)
  );

  //////////////////////////////////////////////////
  // random source and reference functions

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  // one step per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      r = {r[30:0], lfsr[0]};
    end
    return r;
  endfunction

  function automatic logic [joy_w-1:0] joy_select(input logic [1:0] src);
    if (src == src_pad1) begin
      return pad1_key[joy_w-1:0];
    end
    if (src == src_pad2) begin
      return pad2_key[joy_w-1:0];
    end
    return '0;
  endfunction

  function automatic logic [31:0] reg_readback(input logic [adr_w-1:0] adr);
    case (adr)
      reg_osd_ctrl:   return {30'd0, mdl_osd};
      reg_kbd_lo:     return mdl_kbd[31:0];
      reg_kbd_hi:     return mdl_kbd[63:32];
      reg_c64_ctrl:   return {25'd0, mdl_ctrl};
      reg_drive_stat: return {23'd0, drive_motor, drive_led, drive_track};
      default:        return '0;
    endcase
  endfunction

  function automatic logic [31:0] merge_bytes(input logic [31:0] old, input logic [31:0] nw,
                                              input logic [3:0] sel);
    logic [31:0] r;
    r = old;
    for (int b = 0; b < 4; b++) begin
      if (sel[b]) begin
        r[8*b +: 8] = nw[8*b +: 8];
      end
    end
    return r;
  endfunction

  // two-column lag between fetch and display
  function automatic logic [23:0] overlay_pixel(input int x, input int y, input logic de,
                                                input logic [23:0] emu);
    int         byte_idx;
    int         bit_idx;
    logic [7:0] pix_byte;
    if (!de) begin
      return '0;
    end
    if (!mdl_osd[0] || x >= osd_w || y >= (mdl_osd[1] ? osd_h_compact : osd_h)) begin
      return emu;
    end
    if (x < 2) begin
      return osd_bg_rgb;
    end
    byte_idx = y * 32 + (x - 2) / 8;
    bit_idx  = 7 - ((x - 2) % 8);
    pix_byte = fb_model[byte_idx / 4][8 * (byte_idx % 4) +: 8];
    return pix_byte[bit_idx] ? osd_fg_rgb : osd_bg_rgb;
  endfunction

  //////////////////////////////////////////////////
  // monitor and compare

  always @(negedge clk_8mhz) begin : monitor
    logic [fb_aw-1:0] fb_idx;
    logic             exp_ph1;
    logic             exp_ph2;
    logic [23:0]      exp_rgb;
    if (rst) begin
      ph_cnt      = 0;
      prev_ph2    = 1'b0;
      prev_ack    = 1'b0;
      exp_emu_rst = 1'b1;
      mdl_osd     = '0;
      mdl_ctrl    = '0;
      mdl_kbd     = '0;
    end else begin
      // run as it stood during the ph2 cycle
      if (prev_ph2) begin
        exp_emu_rst = ~mdl_ctrl[0];
      end
      assert (emu_rst === exp_emu_rst) else begin
        phase_errs++;
        $display("Mismatch at %0t: emu_rst %b expected %b", $time, emu_rst, exp_emu_rst);
      end
      exp_ph1 = (ph_cnt % 8 == 0) && (ph_cnt != 0);
      exp_ph2 = (ph_cnt % 8 == 4);
      assert (ph1_en === exp_ph1 && ph2_en === exp_ph2) else begin
        phase_errs++;
        $display("Mismatch at %0t: ph1/ph2 %b%b expected %b%b", $time, ph1_en, ph2_en,
                 exp_ph1, exp_ph2);
      end
      prev_ph2 = exp_ph2;
      ph_cnt++;

      assert (!(wb_ack && prev_ack)) else begin
        bus_errs++;
        $display("acknowledge held high for two cycles at %0t", $time);
      end
      prev_ack = wb_ack;

      // bus transfers completing in this cycle
      if (wb_ack && wb_adr[adr_w-1]) begin
        fb_idx = wb_adr[fb_aw+1:2];
        if (wb_we) begin
          fb_model[fb_idx] = merge_bytes(fb_model[fb_idx], wb_dat, wb_sel);
        end else begin
          assert (wb_rdat === fb_model[fb_idx]) else begin
            fb_errs++;
            $display("Mismatch at %0t: fb word %0d read %h expected %h", $time, fb_idx,
                     wb_rdat, fb_model[fb_idx]);
          end
        end
      end else if (wb_ack && !wb_we) begin
        assert (wb_rdat === reg_readback(wb_adr)) else begin
          reg_errs++;
          $display("Mismatch at %0t: reg %h read %h expected %h", $time, wb_adr, wb_rdat,
                   reg_readback(wb_adr));
        end
      end else if (wb_ack && wb_sel == 4'hf) begin
        case (wb_adr)
          reg_osd_ctrl: mdl_osd = wb_dat[osd_ctrl_w-1:0];
          reg_kbd_lo:   mdl_kbd[31:0] = wb_dat;
          reg_kbd_hi:   mdl_kbd[63:32] = wb_dat;
          reg_c64_ctrl: mdl_ctrl = wb_dat[c64_ctrl_w-1:0];
          default:      ;
        endcase
      end

      assert (kbd_mask === mdl_kbd && cart_type === mdl_ctrl[6:5]) else begin
        reg_errs++;
        $display("Mismatch at %0t: kbd_mask %h cart %b expected %h %b", $time, kbd_mask,
                 cart_type, mdl_kbd, mdl_ctrl[6:5]);
      end
      assert (joy1 === joy_select(mdl_ctrl[2:1]) && joy2 === joy_select(mdl_ctrl[4:3]))
      else begin
        joy_errs++;
        $display("Mismatch at %0t: joy1 %h joy2 %h expected %h %h", $time, joy1, joy2,
                 joy_select(mdl_ctrl[2:1]), joy_select(mdl_ctrl[4:3]));
      end
      exp_rgb = overlay_pixel(int'(ras_x), int'(ras_y), vid_de, emu_rgb);
      assert (vid_rgb === exp_rgb) else begin
        pix_errs++;
        $display("Mismatch at %0t: pixel x %0d y %0d got %h expected %h", $time, ras_x,
                 ras_y, vid_rgb, exp_rgb);
      end
    end
  end

  //////////////////////////////////////////////////
  // bus and raster drivers

  task automatic bus_xfer(input logic we, input logic [adr_w-1:0] adr, input logic [31:0] dat,
                          input logic [3:0] sel, output int lat);
    lat = 0;
    @(posedge clk_8mhz);
    wb_cyc <= 1'b1;
    wb_stb <= 1'b1;
    wb_we  <= we;
    wb_adr <= adr;
    wb_dat <= dat;
    wb_sel <= sel;
    do begin
      @(negedge clk_8mhz);
      lat++;
    end while (!wb_ack && lat < ack_limit);
    assert (wb_ack) else begin
      bus_errs++;
      $display("no acknowledge for access to %h at %0t", adr, $time);
    end
    @(posedge clk_8mhz);
    wb_cyc <= 1'b0;
    wb_stb <= 1'b0;
    wb_we  <= 1'b0;
  endtask

  task automatic reg_access(input logic we, input logic [adr_w-1:0] adr,
                            input logic [31:0] dat, input logic [3:0] sel);
    int lat;
    bus_xfer(we, adr, dat, sel, lat);
    assert (lat == 2) else begin
      bus_errs++;
      $display("Mismatch at %0t: register ack after %0d cycles, expected 1", $time, lat - 1);
    end
  endtask

  task automatic fb_access(input logic we, input logic [fb_aw-1:0] word,
                           input logic [31:0] dat, input logic [3:0] sel);
    int lat;
    bus_xfer(we, fb_base | {1'b0, word, 2'b00}, dat, sel, lat);
    if (lat > 2) begin
      late_acks++;
    end
  endtask

  task automatic drive_raster(input int lines);
    @(posedge clk_8mhz);
    vid_vs <= 1'b1;
    @(posedge clk_8mhz);
    vid_vs <= 1'b0;
    for (int y = 0; y < lines; y++) begin
      for (int x = 0; x < line_de; x++) begin
        @(posedge clk_8mhz);
        vid_de  <= 1'b1;
        ras_x   <= 9'(x);
        ras_y   <= 9'(y);
        emu_rgb <= {8'(y), 8'(x), 8'(x ^ y) ^ 8'ha5};
      end
      @(posedge clk_8mhz);
      vid_de <= 1'b0;
      repeat (2) @(posedge clk_8mhz);
      vid_hs <= 1'b1;
      @(posedge clk_8mhz);
      vid_hs <= 1'b0;
    end
  endtask

  //////////////////////////////////////////////////
  // test sequence

  initial begin : stimulus
    logic [fb_aw-1:0] w;
    rst = 1'b1;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we = 1'b0;
    wb_adr = '0;
    wb_dat = '0;
    wb_sel = '0;
    pad1_key = '0;
    pad2_key = '0;
    drive_motor = 1'b0;
    drive_led = 1'b0;
    drive_track = '0;
    vid_hs = 1'b0;
    vid_vs = 1'b0;
    vid_de = 1'b0;
    emu_rgb = '0;
    ras_x = '0;
    ras_y = '0;
    repeat (3) @(posedge clk_8mhz);
    rst <= 1'b0;

    // register round trip
    for (int i = 0; i < 6; i++) begin
      reg_access(1'b1, reg_kbd_lo, rand_bits(32), 4'hf);
      reg_access(1'b1, reg_kbd_hi, rand_bits(32), 4'hf);
      reg_access(1'b1, reg_osd_ctrl, rand_bits(32), 4'hf);
      reg_access(1'b1, reg_c64_ctrl, rand_bits(32), 4'hf);
      reg_access(1'b1, reg_kbd_lo, rand_bits(32), 4'(rand_bits(3)));
      @(posedge clk_8mhz);
      drive_motor <= rand_bits(1) == 32'd1;
      drive_led   <= rand_bits(1) == 32'd1;
      drive_track <= 7'(rand_bits(7));
      reg_access(1'b0, reg_kbd_lo, '0, 4'hf);
      reg_access(1'b0, reg_kbd_hi, '0, 4'hf);
      reg_access(1'b0, reg_osd_ctrl, '0, 4'hf);
      reg_access(1'b0, reg_c64_ctrl, '0, 4'hf);
      reg_access(1'b0, reg_drive_stat, '0, 4'hf);
    end
    reg_access(1'b0, 12'h010, '0, 4'hf);
    reg_access(1'b0, 12'h104, '0, 4'hf);
    reg_access(1'b0, 12'h7fc, '0, 4'hf);

    // every pair of joystick sources
    for (int s = 0; s < 16; s++) begin
      reg_access(1'b1, reg_c64_ctrl, {25'd0, 2'(rand_bits(2)), 4'(s), 1'b0}, 4'hf);
      repeat (6) begin
        @(posedge clk_8mhz);
        pad1_key <= 16'(rand_bits(16));
        pad2_key <= 16'(rand_bits(16));
      end
    end

    // emulator reset follows run
    reg_access(1'b1, reg_c64_ctrl, 32'h1, 4'hf);
    repeat (24) @(negedge clk_8mhz);
    assert (emu_rst == 1'b0) else begin
      phase_errs++;
      $display("emulator reset was not released after run was set");
    end
    reg_access(1'b1, reg_c64_ctrl, 32'h0, 4'hf);
    repeat (24) @(negedge clk_8mhz);
    assert (emu_rst == 1'b1) else begin
      phase_errs++;
      $display("emulator reset did not return after run was cleared");
    end

    // framebuffer pattern, then masked writes
    for (int i = 0; i < fb_words; i++) begin
      fb_access(1'b1, 9'(i), rand_bits(32), 4'hf);
    end
    for (int i = 0; i < 24; i++) begin
      w = 9'(rand_bits(9));
      fb_access(1'b1, w, rand_bits(32), 4'(rand_bits(4)));
      fb_access(1'b0, w, '0, 4'hf);
    end

    // overlay in full, compact and disabled mode
    reg_access(1'b1, reg_osd_ctrl, 32'h1, 4'hf);
    drive_raster(66);
    reg_access(1'b1, reg_osd_ctrl, 32'h3, 4'hf);
    drive_raster(10);
    reg_access(1'b1, reg_osd_ctrl, 32'h0, 4'hf);
    drive_raster(3);

    // host traffic against the scan on rows below the compact window
    reg_access(1'b1, reg_osd_ctrl, 32'h3, 4'hf);
    late_acks = 0;
    fork
      drive_raster(8);
      begin
        for (int i = 0; i < 75; i++) begin
          w = 9'(64 + rand_bits(9) % 448);
          fb_access(1'b1, w, rand_bits(32), 4'(rand_bits(4)));
          fb_access(1'b0, w, '0, 4'hf);
        end
      end
    join
    assert (late_acks > 0) else begin
      fb_errs++;
      $display("no framebuffer access was held off by the scan");
    end

    repeat (4) @(posedge clk_8mhz);
    $display("errors: bus %0d reg %0d joy %0d phase %0d fb %0d pixel %0d", bus_errs,
             reg_errs, joy_errs, phase_errs, fb_errs, pix_errs);
    if (bus_errs + reg_errs + joy_errs + phase_errs + fb_errs + pix_errs == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

  initial begin : watchdog
    #(watchdog_ns);
    $display("timeout: run did not finish within %0d ns", watchdog_ns);
    $display("TESTS FAILED");
    $finish;
  end

endmodule

// ==== rtl/c64_glue_top.sv ====
/*
 * c64 glue top level
 * phase generator, host registers, OSD framebuffer and overlay
 */
module c64_glue_top (
  input  logic                              clk_8mhz,
  input  logic                              rst,
  input  logic                              i_wb_cyc,
  input  logic                              i_wb_stb,
  input  logic                              i_wb_we,
  input  logic [c64_glue_pkg::adr_w-1:0]    i_wb_adr,
  input  logic [31:0]                       i_wb_dat,
  input  logic [3:0]                        i_wb_sel,
  output logic [31:0]                       o_wb_dat,
  output logic                              o_wb_ack,
  input  logic [c64_glue_pkg::key_w-1:0]    i_pad1_key,
  input  logic [c64_glue_pkg::key_w-1:0]    i_pad2_key,
  input  logic                              i_drive_motor,
  input  logic                              i_drive_led,
  input  logic [c64_glue_pkg::track_w-1:0]  i_drive_track,
  input  logic                              i_vid_hs,
  input  logic                              i_vid_vs,
  input  logic                              i_vid_de,
  input  logic [23:0]                       i_emu_rgb,
  output logic [23:0]                       o_vid_rgb,
  output logic [1:0]                        o_cart_type,
  output logic [c64_glue_pkg::kbd_w-1:0]    o_kbd_mask,
  output logic [c64_glue_pkg::joy_w-1:0]    o_joy1,
  output logic [c64_glue_pkg::joy_w-1:0]    o_joy2,
  output logic                              o_ph1_en,
  output logic                              o_ph2_en,
  output logic                              o_emu_rst
);
  import c64_glue_pkg::*;

  logic               run;
  logic               osd_enable;
  logic               osd_compact;
  logic               fb_req;
  logic               fb_ack;
  logic [31:0]        fb_rdata;
  logic               scan_fetch;
  logic [fb_aw+1:0]   scan_addr;
  logic [7:0]         scan_byte;

  phase_enable_gen u_phase (
    .clk_8mhz (clk_8mhz),
    .rst      (rst),
    .i_run    (run),
    .o_ph1_en (o_ph1_en),
    .o_ph2_en (o_ph2_en),
    .o_emu_rst(o_emu_rst)
  );

  core_ctrl_regs u_regs (
    .clk_8mhz     (clk_8mhz),
    .rst          (rst),
    .i_wb_cyc     (i_wb_cyc),
    .i_wb_stb     (i_wb_stb),
    .i_wb_we      (i_wb_we),
    .i_wb_adr     (i_wb_adr),
    .i_wb_dat     (i_wb_dat),
    .i_wb_sel     (i_wb_sel),
    .o_wb_dat     (o_wb_dat),
    .o_wb_ack     (o_wb_ack),
    .i_pad1_key   (i_pad1_key),
    .i_pad2_key   (i_pad2_key),
    .i_drive_motor(i_drive_motor),
    .i_drive_led  (i_drive_led),
    .i_drive_track(i_drive_track),
    .i_fb_ack     (fb_ack),
    .i_fb_rdata   (fb_rdata),
    .o_fb_req     (fb_req),
    .o_run        (run),
    .o_osd_enable (osd_enable),
    .o_osd_compact(osd_compact),
    .o_cart_type  (o_cart_type),
    .o_kbd_mask   (o_kbd_mask),
    .o_joy1       (o_joy1),
    .o_joy2       (o_joy2)
  );

  osd_framebuffer u_fb (
    .clk_8mhz    (clk_8mhz),
    .rst         (rst),
    .i_fb_req    (fb_req),
    .i_wb_we     (i_wb_we),
    .i_wb_adr    (i_wb_adr),
    .i_wb_dat    (i_wb_dat),
    .i_wb_sel    (i_wb_sel),
    .i_scan_fetch(scan_fetch),
    .i_scan_addr (scan_addr),
    .o_fb_ack    (fb_ack),
    .o_fb_rdata  (fb_rdata),
    .o_scan_byte (scan_byte)
  );

  osd_overlay u_overlay (
    .clk_8mhz     (clk_8mhz),
    .rst          (rst),
    .i_osd_enable (osd_enable),
    .i_osd_compact(osd_compact),
    .i_vid_hs     (i_vid_hs),
    .i_vid_vs     (i_vid_vs),
    .i_vid_de     (i_vid_de),
    .i_emu_rgb    (i_emu_rgb),
    .i_scan_byte  (scan_byte),
    .o_scan_fetch (scan_fetch),
    .o_scan_addr  (scan_addr),
    .o_vid_rgb    (o_vid_rgb)
  );

endmodule

// ==== rtl/osd_overlay.sv ====
/*
 * OSD overlay
 * tracks the raster, fetches OSD bytes inside the window and
 * lays the 1-bit pixels over the emulator video
 */
module osd_overlay (
  input  logic                              clk_8mhz,
  input  logic                              rst,
  input  logic                              i_osd_enable,
  input  logic                              i_osd_compact,
  input  logic                              i_vid_hs,
  input  logic                              i_vid_vs,
  input  logic                              i_vid_de,
  input  logic [23:0]                       i_emu_rgb,
  input  logic [7:0]                        i_scan_byte,
  output logic                              o_scan_fetch,
  output logic [c64_glue_pkg::fb_aw+1:0]    o_scan_addr,
  output logic [23:0]                       o_vid_rgb
);
  import c64_glue_pkg::*;

  logic [8:0] osd_x;
  logic [8:0] osd_y;
  logic       in_win;
  logic       osd_active;
  logic       fetch_q;
  logic [7:0] pix_shift;

  //////////////////////////////////////////////////
  // raster counters

  always_ff @(posedge clk_8mhz) begin
    if (rst) begin
      osd_x <= '0;
      osd_y <= '0;
    end else if (i_vid_vs) begin
      osd_y <= '0;
    end else if (i_vid_hs) begin
      osd_x <= '0;
      // x only moves on de, so nonzero means a visible row
      if (osd_x != '0) begin
        osd_y <= osd_y + 9'd1;
      end
    end else if (i_vid_de) begin
      osd_x <= osd_x + 9'd1;
    end
  end

  //////////////////////////////////////////////////
  // window and fetch

  assign in_win = (osd_x < osd_w) &&
                  (i_osd_compact ? (osd_y < osd_h_compact) : (osd_y < osd_h));
  assign osd_active = i_osd_enable && i_vid_de && in_win;

  // 32 bytes per row, 8 pixels per byte
  assign o_scan_fetch = osd_active && (osd_x[2:0] == 3'd0);
  assign o_scan_addr  = {osd_y[5:0], osd_x[7:3]};

  always_ff @(posedge clk_8mhz) begin
    if (rst) begin
      fetch_q <= 1'b0;
    end else begin
      fetch_q <= o_scan_fetch;
    end
  end

  // byte arrives one cycle after the fetch
  always_ff @(posedge clk_8mhz) begin
    if (fetch_q) begin
      pix_shift <= i_scan_byte;
    end else if (i_vid_hs) begin
      pix_shift <= '0;
    end else begin
      pix_shift <= {pix_shift[6:0], 1'b0};
    end
  end

  //////////////////////////////////////////////////
  // mixer

  always_comb begin
    if (!i_vid_de) begin
      o_vid_rgb = '0;
    end else if (osd_active) begin
      o_vid_rgb = pix_shift[7] ? osd_fg_rgb : osd_bg_rgb;
    end else begin
      o_vid_rgb = i_emu_rgb;
    end
  end

endmodule

// ==== rtl/osd_framebuffer.sv ====
/*
 * OSD framebuffer
 * 512 x 32 single-port array, one bit per pixel, shared by the
 * host and the display scan; the scan always wins the cycle
 */
module osd_framebuffer (
  input  logic                              clk_8mhz,
  input  logic                              rst,
  input  logic                              i_fb_req,
  input  logic                              i_wb_we,
  input  logic [c64_glue_pkg::adr_w-1:0]    i_wb_adr,
  input  logic [31:0]                       i_wb_dat,
  input  logic [3:0]                        i_wb_sel,
  input  logic                              i_scan_fetch,
  input  logic [c64_glue_pkg::fb_aw+1:0]    i_scan_addr,
  output logic                              o_fb_ack,
  output logic [31:0]                       o_fb_rdata,
  output logic [7:0]                        o_scan_byte
);
  import c64_glue_pkg::*;

  fb_word_u             mem [fb_words];
  fb_word_u             wr_word;
  fb_word_u             rd_q;
  logic [fb_aw-1:0]     mem_addr;
  logic [1:0]           lane_q;
  logic                 host_go;
  logic                 host_wr;

  // host waits out any scan fetch
  assign host_go  = i_fb_req & ~i_scan_fetch;
  assign host_wr  = host_go & i_wb_we;
  assign mem_addr = i_scan_fetch ? i_scan_addr[fb_aw+1:2] : i_wb_adr[fb_aw+1:2];
  assign wr_word.word = i_wb_dat;

  always_ff @(posedge clk_8mhz) begin
    if (host_wr) begin
      for (int b = 0; b < 4; b++) begin
        if (i_wb_sel[b]) begin
          mem[mem_addr].bytes[b] <= wr_word.bytes[b];
        end
      end
    end
    rd_q   <= mem[mem_addr];
    lane_q <= i_scan_addr[1:0];
  end

  // data comes out with the ack
  always_ff @(posedge clk_8mhz) begin
    if (rst) begin
      o_fb_ack <= 1'b0;
    end else begin
      o_fb_ack <= host_go;
    end
  end

  assign o_fb_rdata  = rd_q.word;
  assign o_scan_byte = rd_q.bytes[lane_q];

  // a request that loses its slot to the scan is still pending next cycle
  a_host_held: assert property (@(posedge clk_8mhz) disable iff (rst)
    i_fb_req && i_scan_fetch |=> i_fb_req);

  // no second write while acking
  a_host_wr_slot: assert property (@(posedge clk_8mhz) disable iff (rst)
    host_wr |-> !o_fb_ack);

endmodule

// ==== rtl/core_ctrl_regs.sv ====
/*
 * host control registers
 * wishbone classic slave with the overlay, emulator and keyboard
 * registers, drive status readback, joystick routing and the
 * handshake toward the OSD framebuffer
 */
module core_ctrl_regs (
  input  logic                                clk_8mhz,
  input  logic                                rst,
  input  logic                                i_wb_cyc,
  input  logic                                i_wb_stb,
  input  logic                                i_wb_we,
  input  logic [c64_glue_pkg::adr_w-1:0]      i_wb_adr,
  input  logic [31:0]                         i_wb_dat,
  input  logic [3:0]                          i_wb_sel,
  output logic [31:0]                         o_wb_dat,
  output logic                                o_wb_ack,
  input  logic [c64_glue_pkg::key_w-1:0]      i_pad1_key,
  input  logic [c64_glue_pkg::key_w-1:0]      i_pad2_key,
  input  logic                                i_drive_motor,
  input  logic                                i_drive_led,
  input  logic [c64_glue_pkg::track_w-1:0]    i_drive_track,
  input  logic                                i_fb_ack,
  input  logic [31:0]                         i_fb_rdata,
  output logic                                o_fb_req,
  output logic                                o_run,
  output logic                                o_osd_enable,
  output logic                                o_osd_compact,
  output logic [1:0]                          o_cart_type,
  output logic [c64_glue_pkg::kbd_w-1:0]      o_kbd_mask,
  output logic [c64_glue_pkg::joy_w-1:0]      o_joy1,
  output logic [c64_glue_pkg::joy_w-1:0]      o_joy2
);
  import c64_glue_pkg::*;

  logic                  wb_req;
  logic                  fb_sel;
  logic                  reg_hit;
  logic                  reg_wr;
  logic                  reg_ack;
  logic [31:0]           rd_mux;
  logic [31:0]           rd_q;
  logic [osd_ctrl_w-1:0] osd_ctrl;
  logic [c64_ctrl_w-1:0] c64_ctrl;

  assign wb_req  = i_wb_cyc & i_wb_stb;
  assign fb_sel  = (i_wb_adr >= fb_base);
  // one ack per request, the master drops stb after it
  assign reg_hit = wb_req & ~fb_sel & ~reg_ack;
  // full-word writes only
  assign reg_wr  = reg_hit & i_wb_we & (i_wb_sel == 4'hf);

  // held until the framebuffer answers
  assign o_fb_req = wb_req & fb_sel & ~i_fb_ack;

  //////////////////////////////////////////////////
  // control registers

  always_ff @(posedge clk_8mhz) begin
    if (rst) begin
      osd_ctrl   <= '0;
      c64_ctrl   <= '0;
      o_kbd_mask <= '0;
    end else if (reg_wr) begin
      case (i_wb_adr)
        reg_osd_ctrl: osd_ctrl <= i_wb_dat[osd_ctrl_w-1:0];
        reg_kbd_lo:   o_kbd_mask[31:0] <= i_wb_dat;
        reg_kbd_hi:   o_kbd_mask[63:32] <= i_wb_dat;
        reg_c64_ctrl: c64_ctrl <= i_wb_dat[c64_ctrl_w-1:0];
        default:      ;
      endcase
    end
  end

  assign o_osd_enable  = osd_ctrl[0];
  assign o_osd_compact = osd_ctrl[1];
  assign o_run         = c64_ctrl[0];
  assign o_cart_type   = c64_ctrl[6:5];

  //////////////////////////////////////////////////
  // readback and acknowledge

  // unmapped addresses read as zero
  always_comb begin
    case (i_wb_adr)
      reg_osd_ctrl:   rd_mux = {{(32-osd_ctrl_w){1'b0}}, osd_ctrl};
      reg_kbd_lo:     rd_mux = o_kbd_mask[31:0];
      reg_kbd_hi:     rd_mux = o_kbd_mask[63:32];
      reg_c64_ctrl:   rd_mux = {{(32-c64_ctrl_w){1'b0}}, c64_ctrl};
      reg_drive_stat: rd_mux = {{(30-track_w){1'b0}}, i_drive_motor, i_drive_led, i_drive_track};
      default:        rd_mux = '0;
    endcase
  end

  always_ff @(posedge clk_8mhz) begin
    if (rst) begin
      reg_ack <= 1'b0;
    end else begin
      reg_ack <= reg_hit;
    end
  end

  always_ff @(posedge clk_8mhz) begin
    if (reg_hit) begin
      rd_q <= rd_mux;
    end
  end

  assign o_wb_ack = reg_ack | i_fb_ack;
  assign o_wb_dat = i_fb_ack ? i_fb_rdata : rd_q;

  //////////////////////////////////////////////////
  // joystick routing

  function automatic logic [joy_w-1:0] pick_joy(input logic [1:0] src);
    case (src)
      src_pad1: pick_joy = i_pad1_key[joy_w-1:0];
      src_pad2: pick_joy = i_pad2_key[joy_w-1:0];
      default:  pick_joy = '0;
    endcase
  endfunction

  assign o_joy1 = pick_joy(c64_ctrl[2:1]);
  assign o_joy2 = pick_joy(c64_ctrl[4:3]);

  // covers the framebuffer ack path as well
  a_ack_in_cycle: assert property (@(posedge clk_8mhz) disable iff (rst)
    o_wb_ack |-> i_wb_cyc);

endmodule

// ==== rtl/phase_enable_gen.sv ====
/*
 * 1 MHz phase enable generator
 * splits the 8 MHz clock into ph1/ph2 enables and holds the
 * emulator in reset until a ph2 boundary after run is set
 */
module phase_enable_gen (
  input  logic clk_8mhz,
  input  logic rst,
  input  logic i_run,
  output logic o_ph1_en,
  output logic o_ph2_en,
  output logic o_emu_rst
);
  import c64_glue_pkg::*;

  logic [2:0] phase_cnt;
  logic [2:0] phase_nxt;

  assign phase_nxt = phase_cnt + 3'd1;

  // enables are registered against the next count
  always_ff @(posedge clk_8mhz) begin
    if (rst) begin
      phase_cnt <= '0;
      o_ph1_en  <= 1'b0;
      o_ph2_en  <= 1'b0;
    end else begin
      phase_cnt <= phase_nxt;
      o_ph1_en  <= (phase_nxt == ph1_phase);
      o_ph2_en  <= (phase_nxt == ph2_phase);
    end
  end

  // released only at ph2, so the first phase seen is ph1
  always_ff @(posedge clk_8mhz) begin
    if (rst) begin
      o_emu_rst <= 1'b1;
    end else if (o_ph2_en) begin
      o_emu_rst <= ~i_run;
    end
  end

  a_ph_exclusive: assert property (@(posedge clk_8mhz) disable iff (rst)
    !(o_ph1_en && o_ph2_en));

endmodule

// ==== rtl/c64_glue_pkg.sv ====
/*
 * c64 glue shared definitions
 * host address map, register widths, overlay colours and geometry,
 * and the framebuffer word seen as one word or as four bytes
 */
package c64_glue_pkg;

  //////////////////////////////////////////////////
  // host address map

  localparam int adr_w = 12;

  localparam logic [adr_w-1:0] reg_osd_ctrl   = 12'h000;
  localparam logic [adr_w-1:0] reg_kbd_lo     = 12'h004;
  localparam logic [adr_w-1:0] reg_kbd_hi     = 12'h008;
  localparam logic [adr_w-1:0] reg_c64_ctrl   = 12'h00c;
  localparam logic [adr_w-1:0] reg_drive_stat = 12'h100;

  // 2 KB window, selected by address bit 11
  localparam logic [adr_w-1:0] fb_base = 12'h800;
  localparam int fb_words = 512;
  localparam int fb_aw    = $clog2(fb_words);

  //////////////////////////////////////////////////
  // register widths

  // run, port 1 src, port 2 src, cartridge type
  localparam int c64_ctrl_w = 7;
  localparam int osd_ctrl_w = 2;
  localparam int kbd_w      = 64;
  localparam int key_w      = 16;
  localparam int joy_w      = 5;
  localparam int track_w    = 7;

  // joystick source codes, anything else is idle
  localparam logic [1:0] src_pad1 = 2'b01;
  localparam logic [1:0] src_pad2 = 2'b10;

  // counter values of the two 1 MHz phases
  localparam logic [2:0] ph1_phase = 3'd0;
  localparam logic [2:0] ph2_phase = 3'd4;

  //////////////////////////////////////////////////
  // overlay geometry and colours

  localparam int osd_w         = 256;
  localparam int osd_h         = 64;
  localparam int osd_h_compact = 8;

  localparam logic [23:0] osd_fg_rgb = 24'hff_ff_ff;
  localparam logic [23:0] osd_bg_rgb = 24'h30_40_50;

  // host reads the word, the scan reads one byte lane
  typedef union packed {
    logic [31:0]     word;
    logic [3:0][7:0] bytes;
  } fb_word_u;

endpackage
